/* hdl/core_cfg_pkg.sv */
package core_cfg_pkg;

  localparam int tag_width = 5;        // 32 physical tags
  typedef logic [tag_width-1:0] tag_t;

  localparam int num_fu = 4;           // one station entry per unit
  localparam int num_kinds = 3;
  localparam int op_width = 3;         // width of the opcode field in entries and records

  typedef enum logic [1:0] {
    fu_alu,
    fu_mem,
    fu_mult
  } fu_kind_t;

  // unit i is of kind fu_list[i]
  localparam fu_kind_t fu_list [num_fu] = '{fu_alu, fu_alu, fu_mem, fu_mult};

  // pipeline depth per kind, indexed by fu_kind_t
  localparam int fu_latency [num_kinds] = '{1, 2, 3};

  localparam int first_free_tag = 8;   // tags 0..7 start as the architectural mapping

  typedef struct packed {
    tag_t tag;
    logic ready;                       // value already broadcast
  } operand_t;

  typedef struct packed {
    logic                busy;         // entry holds a waiting op
    logic [op_width-1:0] op;
    tag_t                dest_tag;
    operand_t            src1;
    operand_t            src2;
  } rs_entry_t;

  typedef struct packed {
    logic                valid;        // single cycle issue pulse
    tag_t                dest_tag;
    tag_t                src1_tag;
    tag_t                src2_tag;
    logic [op_width-1:0] op;
  } issue_rec_t;

  localparam rs_entry_t rs_entry_reset = '{busy: 1'b0, op: '0, dest_tag: '0,
                                           src1: '0, src2: '0};
  localparam issue_rec_t issue_rec_idle = '0;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

  import core_cfg_pkg::*;

  localparam int num_arch_regs = 8;
  typedef logic [$clog2(num_arch_regs)-1:0] arch_reg_t;

  typedef enum logic [op_width-1:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_ld  = 3'd3,   // load goes to the memory unit
    op_mul = 3'd4
  } opcode_t;

  // opcode to unit kind, unused codes fall back to the alu
  localparam fu_kind_t op_unit [2**op_width] = '{
    fu_alu,   // op_add
    fu_alu,   // op_sub
    fu_alu,   // op_and
    fu_mem,   // op_ld
    fu_mult,  // op_mul
    fu_alu,
    fu_alu,
    fu_alu
  };

endpackage

/* hdl/dispatch_if.sv */
interface dispatch_if;

  import core_cfg_pkg::*;
  import isa_pkg::*;

  logic     valid;      // renamed instruction present
  fu_kind_t kind;       // unit kind the op needs
  opcode_t  op;
  tag_t     dest_tag;   // freshly allocated tag
  operand_t src1;
  operand_t src2;
  logic     hazard;     // no free entry of that kind

  // accepted when valid && !hazard
  modport rename (output valid, kind, op, dest_tag, src1, src2,
                  input  hazard);

  modport station (input  valid, kind, op, dest_tag, src1, src2,
                   output hazard);

endinterface

/* hdl/issue_if.sv */
interface issue_if;

  import core_cfg_pkg::*;

  issue_rec_t [num_fu-1:0] rec;    // one issue slot per unit
  logic       [num_fu-1:0] busy;   // unit cannot take an op this cycle

  // station side drives the records
  modport station (
    output rec,
    input  busy
  );

  // execution side must take every valid record
  modport exec (
    input  rec,
    output busy
  );

endinterface

/* hdl/rename_table.sv */
module rename_table (
  input  logic               clock,
  input  logic               reset,
  input  logic               in_valid,
  input  isa_pkg::opcode_t   in_op,
  input  isa_pkg::arch_reg_t dest_reg,
  input  isa_pkg::arch_reg_t src1_reg,
  input  isa_pkg::arch_reg_t src2_reg,
  input  logic               cdb_valid,
  input  core_cfg_pkg::tag_t cdb_tag,
  output core_cfg_pkg::tag_t alloc_tag,
  dispatch_if.rename         disp
);

  import core_cfg_pkg::*;
  import isa_pkg::*;

  tag_t                     map_tag [num_arch_regs];  // current producer tag per register
  logic [num_arch_regs-1:0] map_ready;                // producer already broadcast
  logic [num_arch_regs-1:0] cdb_hit;                  // mapping matches this cycle's broadcast
  logic [num_arch_regs-1:0] pending_hit;              // next tag still owned by a waiting reg
  tag_t                     next_tag;                 // round robin allocation pointer
  logic                     accept;

  always_comb begin
    for (int r = 0; r < num_arch_regs; r++) begin
      cdb_hit[r]     = cdb_valid && map_tag[r] == cdb_tag;
      pending_hit[r] = !(map_ready[r] || cdb_hit[r]) && map_tag[r] == next_tag;
    end
  end

  assign accept    = disp.valid && !disp.hazard;  // station took it
  assign alloc_tag = next_tag;

  // dispatch packet from the current mapping
  always_comb begin
    disp.valid      = in_valid;
    disp.op         = in_op;
    disp.kind       = op_unit[in_op];
    disp.dest_tag   = next_tag;
    disp.src1.tag   = map_tag[src1_reg];
    disp.src1.ready = map_ready[src1_reg] || cdb_hit[src1_reg];  // same cycle bypass
    disp.src2.tag   = map_tag[src2_reg];
    disp.src2.ready = map_ready[src2_reg] || cdb_hit[src2_reg];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < num_arch_regs; r++) begin
        map_tag[r]   <= tag_t'(r);   // identity mapping
        map_ready[r] <= 1'b1;
      end
      next_tag <= tag_t'(first_free_tag);
    end else begin
      for (int r = 0; r < num_arch_regs; r++) begin
        if (cdb_hit[r]) begin
          map_ready[r] <= 1'b1;      // every register waiting on this tag
        end
      end
      // destination remap wins over a wakeup of the old tag
      if (accept) begin
        map_tag[dest_reg]   <= next_tag;
        map_ready[dest_reg] <= 1'b0;
        next_tag            <= next_tag + 1'b1;  // wraps through all 32 tags
      end
    end
  end

  // a tag is only reused once its previous producer has broadcast
  a_fresh_tag: assert property (@(posedge clock) disable iff (reset)
    accept |-> pending_hit == '0);

endmodule

/* hdl/reservation_station.sv */
module reservation_station (
  input  logic               clock,
  input  logic               reset,
  dispatch_if.station        disp,
  input  logic               cdb_valid,
  input  core_cfg_pkg::tag_t cdb_tag,
  issue_if.station           iss
);

  import core_cfg_pkg::*;
  import isa_pkg::*;

  rs_entry_t [num_fu-1:0] rs;           // one entry per unit
  rs_entry_t [num_fu-1:0] next_rs;
  logic      [num_fu-1:0] t1_cdb;       // first operand matches the broadcast
  logic      [num_fu-1:0] t2_cdb;       // second operand, own match
  logic      [num_fu-1:0] t1_ready;
  logic      [num_fu-1:0] t2_ready;
  logic      [num_fu-1:0] issue_ok;     // entry leaves this cycle
  logic      [num_fu-1:0] entry_free;
  logic      [num_fu-1:0] entry_match;  // free and of the requested kind
  logic      [num_fu-1:0] written;      // entry chosen for the new op
  logic                   accept;

  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      t1_cdb[i]      = cdb_valid && rs[i].src1.tag == cdb_tag;
      t2_cdb[i]      = cdb_valid && rs[i].src2.tag == cdb_tag;
      t1_ready[i]    = rs[i].src1.ready || t1_cdb[i];   // ready or woken right now
      t2_ready[i]    = rs[i].src2.ready || t2_cdb[i];
      issue_ok[i]    = rs[i].busy && t1_ready[i] && t2_ready[i] && !iss.busy[i];
      entry_free[i]  = !rs[i].busy || issue_ok[i];      // an issuing entry can be refilled
      entry_match[i] = entry_free[i] && fu_list[i] == disp.kind;
    end
  end

  assign disp.hazard = disp.valid && entry_match == '0;
  assign accept      = disp.valid && !disp.hazard;

  always_comb begin
    next_rs = rs;
    written = '0;

    // wakeup and issue
    for (int i = 0; i < num_fu; i++) begin
      iss.rec[i] = issue_rec_idle;
      if (t1_cdb[i]) begin
        next_rs[i].src1.ready = 1'b1;
      end
      if (t2_cdb[i]) begin
        next_rs[i].src2.ready = 1'b1;
      end
      if (issue_ok[i]) begin
        iss.rec[i].valid    = 1'b1;
        iss.rec[i].dest_tag = rs[i].dest_tag;
        iss.rec[i].src1_tag = rs[i].src1.tag;
        iss.rec[i].src2_tag = rs[i].src2.tag;
        iss.rec[i].op       = rs[i].op;
        next_rs[i]          = rs_entry_reset;   // slot emptied by issue
      end
    end

    // dispatch into the lowest matching entry
    for (int i = 0; i < num_fu; i++) begin
      if (accept && entry_match[i] && written == '0) begin
        written[i]          = 1'b1;
        next_rs[i].busy     = 1'b1;
        next_rs[i].op       = disp.op;
        next_rs[i].dest_tag = disp.dest_tag;
        next_rs[i].src1     = disp.src1;       // readiness already bypassed in rename
        next_rs[i].src2     = disp.src2;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rs <= '{default: rs_entry_reset};
    end else begin
      rs <= next_rs;
    end
  end

  // rename kind lookup and entry selection agree on the unit
  for (genvar i = 0; i < num_fu; i++) begin : g_chk
    a_entry_kind: assert property (@(posedge clock) disable iff (reset)
      rs[i].busy |-> op_unit[rs[i].op] == fu_list[i]);
  end

  // a stalled op stays on the input until the station takes it
  a_hold_on_hazard: assert property (@(posedge clock) disable iff (reset)
    disp.hazard |=> disp.valid && disp.op == $past(disp.op));

endmodule

/* hdl/exec_complete.sv */
module exec_complete (
  input  logic               clock,
  input  logic               reset,
  issue_if.exec              iss,
  output logic               cdb_valid,
  output core_cfg_pkg::tag_t cdb_tag
);

  import core_cfg_pkg::*;

  logic [num_fu-1:0] last_v;     // result at the pipeline end
  logic [num_fu-1:0] hold_v;     // result that lost arbitration
  logic [num_fu-1:0] out_v;      // unit requests the bus
  logic [num_fu-1:0] grant;
  logic [num_fu-1:0] stall_u;    // freeze unit pipeline
  tag_t [num_fu-1:0] last_tag;
  tag_t [num_fu-1:0] hold_tag;
  tag_t [num_fu-1:0] out_tag;

  for (genvar i = 0; i < num_fu; i++) begin : g_unit
    localparam int depth = fu_latency[fu_list[i]];

    logic [depth-1:0] pipe_v;
    tag_t [depth-1:0] pipe_tag;

    always_ff @(posedge clock) begin
      if (reset) begin
        pipe_v <= '0;
      end else if (!stall_u[i]) begin
        for (int s = depth - 1; s > 0; s--) begin
          pipe_v[s] <= pipe_v[s-1];
        end
        pipe_v[0] <= iss.rec[i].valid;   // new op enters stage 0
      end
    end

    always_ff @(posedge clock) begin
      if (!stall_u[i]) begin
        for (int s = depth - 1; s > 0; s--) begin
          pipe_tag[s] <= pipe_tag[s-1];
        end
        pipe_tag[0] <= iss.rec[i].dest_tag;
      end
    end

    assign last_v[i]   = pipe_v[depth-1];
    assign last_tag[i] = pipe_tag[depth-1];

    // station honours busy, so nothing is dropped on entry
    a_no_issue_busy: assert property (@(posedge clock) disable iff (reset)
      iss.rec[i].valid |-> !iss.busy[i]);
  end

  // fixed priority, lowest unit index wins
  always_comb begin
    grant     = '0;
    cdb_valid = 1'b0;
    cdb_tag   = '0;
    for (int i = 0; i < num_fu; i++) begin
      out_v[i]   = hold_v[i] || last_v[i];
      out_tag[i] = hold_v[i] ? hold_tag[i] : last_tag[i];  // older result goes first
      if (out_v[i] && !cdb_valid) begin
        grant[i]  = 1'b1;
        cdb_valid = 1'b1;
        cdb_tag   = out_tag[i];
      end
    end
  end

  // holding full, a result right behind it and no grant
  assign stall_u  = hold_v & last_v & ~grant;
  assign iss.busy = stall_u;

  always_ff @(posedge clock) begin
    if (reset) begin
      hold_v <= '0;
    end else begin
      for (int i = 0; i < num_fu; i++) begin
        if (hold_v[i]) begin
          if (grant[i]) begin
            hold_v[i] <= last_v[i];               // waiting result moves up
          end
        end else begin
          hold_v[i] <= last_v[i] && !grant[i];    // park the loser
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < num_fu; i++) begin
      if (!hold_v[i] || grant[i]) begin
        hold_tag[i] <= last_tag[i];
      end
    end
  end

endmodule

/* hdl/issue_core.sv */
module issue_core (
  input  logic               clock,
  input  logic               reset,
  input  logic               dispatch_valid,
  input  isa_pkg::opcode_t   dispatch_op,
  input  isa_pkg::arch_reg_t dest_reg,
  input  isa_pkg::arch_reg_t src1_reg,
  input  isa_pkg::arch_reg_t src2_reg,
  output logic               stall,          // hold the instruction
  output core_cfg_pkg::tag_t dispatch_tag,   // tag given to dest_reg
  output logic               cdb_valid,
  output core_cfg_pkg::tag_t cdb_tag
);

  dispatch_if disp ();   // rename to station
  issue_if    iss ();    // station to units

  rename_table u_rename (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (dispatch_valid),
    .in_op     (dispatch_op),
    .dest_reg  (dest_reg),
    .src1_reg  (src1_reg),
    .src2_reg  (src2_reg),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .alloc_tag (dispatch_tag),
    .disp      (disp.rename)
  );

  reservation_station u_station (
    .clock     (clock),
    .reset     (reset),
    .disp      (disp.station),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .iss       (iss.station)
  );

  // units and bus arbiter, broadcast feeds back to both blocks above
  exec_complete u_exec (
    .clock     (clock),
    .reset     (reset),
    .iss       (iss.exec),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag)
  );

  assign stall = disp.hazard;

endmodule

/* sim/issue_core_tb.sv */
module issue_core_tb;

  import core_cfg_pkg::*;
  import isa_pkg::*;

  localparam int   nrows       = 16;
  localparam int   num_fixed   = 11;   // rows written by hand, the rest come from the lcg
  localparam int   max_latency = 3;
  localparam int   seed        = 59;
  localparam tag_t first_tag   = 8;    // tags 0..7 are the reset mapping

  logic      clock;
  logic      reset;
  logic      dispatch_valid;
  opcode_t   dispatch_op;
  arch_reg_t dest_reg;
  arch_reg_t src1_reg;
  arch_reg_t src2_reg;
  logic      stall;
  tag_t      dispatch_tag;
  logic      cdb_valid;
  tag_t      cdb_tag;

  // stimulus table, one row per instruction
  string     row_name  [nrows];
  opcode_t   row_op    [nrows];
  arch_reg_t row_dst   [nrows];
  arch_reg_t row_src1  [nrows];
  arch_reg_t row_src2  [nrows];
  int        row_idle  [nrows];   // idle cycles after the row
  int        row_stall [nrows];   // 0 unchecked, 1 taken at once, 2 stalled at first
  int        row_extra [nrows];   // cycles lost to the arbiter, -1 unchecked

  // scoreboard state
  tag_t model_map [8];            // register to tag
  tag_t model_next;               // round robin pointer
  bit   allocated [32];
  int   seen      [32];           // broadcasts per tag
  int   acc_cyc   [32];
  int   exp_cyc   [32];
  int   tag_row   [32];
  tag_t src1_of   [32];           // producer tags of the sources
  tag_t src2_of   [32];

  int unsigned rng_state;
  int cyc;
  int limit;
  int errors;
  int checks;
  int dispatched;
  int done;

  issue_core DUT (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_op    (dispatch_op),
    .dest_reg       (dest_reg),
    .src1_reg       (src1_reg),
    .src2_reg       (src2_reg),
    .stall          (stall),
    .dispatch_tag   (dispatch_tag),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag)
  );

  always #50 clock = ~clock;

  function automatic int unsigned lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state >> 16;   // low bits of an lcg cycle too fast
  endfunction

  // alu ops take one cycle, loads two, multiplies three
  function automatic int unit_latency(input opcode_t op);
    case (op)
      op_ld:   return 2;
      op_mul:  return 3;
      default: return 1;
    endcase
  endfunction

  task automatic check_tag(input string name, input tag_t exp, input tag_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  task automatic set_row(input int i, input string name, input opcode_t op,
                         input arch_reg_t d, input arch_reg_t s1, input arch_reg_t s2,
                         input int idle, input int st, input int extra);
    row_name[i]  = name;
    row_op[i]    = op;
    row_dst[i]   = d;
    row_src1[i]  = s1;
    row_src2[i]  = s2;
    row_idle[i]  = idle;
    row_stall[i] = st;
    row_extra[i] = extra;
  endtask

  task automatic fill_table();
    int unsigned r [6];
    set_row(0,  "first_add", op_add, 1, 2, 3, 6, 1, 0);   // first tag after reset
    set_row(1,  "iso_ld",    op_ld,  2, 4, 5, 6, 1, 0);
    set_row(2,  "iso_mul",   op_mul, 3, 1, 2, 6, 1, 0);
    set_row(3,  "chain_mul", op_mul, 5, 3, 6, 0, 0, -1);  // chain of true dependencies
    set_row(4,  "chain_add", op_add, 6, 5, 5, 0, 0, -1);
    set_row(5,  "chain_ld",  op_ld,  7, 6, 1, 6, 0, -1);
    set_row(6,  "haz_mul0",  op_mul, 1, 2, 3, 0, 1, -1);
    set_row(7,  "haz_mul1",  op_mul, 4, 1, 1, 0, 1, -1);  // takes the entry haz_mul0 frees
    set_row(8,  "haz_mul2",  op_mul, 5, 1, 1, 6, 2, -1);  // no mult entry until haz_mul1 issues
    set_row(9,  "cont_ld",   op_ld,  6, 2, 3, 0, 1, 1);   // loses the bus to the alu
    set_row(10, "cont_add",  op_add, 7, 2, 3, 6, 1, 0);
    for (int i = num_fixed; i < nrows; i++) begin
      for (int k = 0; k < 6; k++) begin
        r[k] = lcg_next();
      end
      set_row(i, $sformatf("rand_%0d", i), opcode_t'(r[0] % 5), arch_reg_t'(r[1] % 8),
              arch_reg_t'(r[2] % 8), arch_reg_t'(r[3] % 8), int'(r[4] % 3), 0, -1);
    end
  endtask

  task automatic apply_row(input int i);
    tag_t t;
    @(negedge clock);
    dispatch_valid = 1'b1;
    dispatch_op    = row_op[i];
    dest_reg       = row_dst[i];
    src1_reg       = row_src1[i];
    src2_reg       = row_src2[i];
    #25;                                     // settled, well ahead of the rising edge
    if (row_stall[i] != 0) begin
      check_bit({row_name[i], " stall"}, row_stall[i] == 2, stall);
    end
    while (stall) begin                      // held until the station has room
      @(negedge clock);
      #25;
    end
    t = model_next;                          // accepted at the coming edge
    check_tag({row_name[i], " tag"}, t, dispatch_tag);
    allocated[t] = 1'b1;
    tag_row[t]   = i;
    acc_cyc[t]   = cyc;
    src1_of[t]   = model_map[row_src1[i]];
    src2_of[t]   = model_map[row_src2[i]];
    exp_cyc[t]   = row_extra[i] < 0 ? -1 : cyc + unit_latency(row_op[i]) + 1 + row_extra[i];
    model_map[row_dst[i]] = t;
    model_next++;
    dispatched++;
    repeat (row_idle[i]) begin
      @(negedge clock);
      dispatch_valid = 1'b0;
    end
  endtask

  task automatic note_broadcast(input tag_t t);
    if (!allocated[t]) begin
      errors++;
      $display("ERROR: tag %0d was broadcast but never allocated", t);
    end else if (seen[t] != 0) begin
      errors++;
      $display("ERROR: %s broadcast tag %0d a second time", row_name[tag_row[t]], t);
    end else begin
      // a producer must already have been on the bus
      if ((src1_of[t] >= first_tag && seen[src1_of[t]] == 0) ||
          (src2_of[t] >= first_tag && seen[src2_of[t]] == 0)) begin
        errors++;
        $display("ERROR: %s broadcast tag %0d before its producer", row_name[tag_row[t]], t);
      end
      done++;
      $display("%s: tag %0d accepted in cycle %0d, broadcast in cycle %0d",
               row_name[tag_row[t]], t, acc_cyc[t], cyc);
    end
    if (allocated[t]) begin
      seen[t]++;
    end
  endtask

  // bus is driven from flops only, stable at the falling edge
  always @(negedge clock) begin
    for (int t = 8; t < 32; t++) begin
      if (allocated[t] && exp_cyc[t] == cyc) begin
        check_bit({row_name[tag_row[t]], " cdb_valid"}, 1'b1, cdb_valid);
        check_tag({row_name[tag_row[t]], " cdb_tag"}, tag_t'(t), cdb_tag);
      end
    end
    if (cdb_valid) begin
      note_broadcast(cdb_tag);
    end
  end

  always @(posedge clock) begin
    cyc++;
    if (cyc > limit) begin
      $display("ERROR: timeout at cycle %0d, %0d of %0d tags broadcast", cyc, done, dispatched);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    int idle_sum;
    clock          = 1'b0;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_op    = op_add;
    dest_reg       = '0;
    src1_reg       = '0;
    src2_reg       = '0;
    rng_state      = seed;
    fill_table();
    idle_sum = 0;
    for (int i = 0; i < nrows; i++) begin
      idle_sum += row_idle[i];
    end
    limit = nrows * (max_latency + 8) + idle_sum;
    for (int r = 0; r < 8; r++) begin
      model_map[r] = tag_t'(r);              // identity mapping out of reset
    end
    model_next = first_tag;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    #25;
    check_bit("reset stall", 1'b0, stall);
    check_bit("reset cdb_valid", 1'b0, cdb_valid);
    for (int i = 0; i < nrows; i++) begin
      apply_row(i);
    end
    @(negedge clock);
    dispatch_valid = 1'b0;
    while (done < dispatched) begin
      @(negedge clock);
    end
    repeat (6) @(negedge clock);             // room for a late duplicate
    $display("%0d tests, %0d checks, %0d errors", dispatched, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* build.f */
hdl/core_cfg_pkg.sv
hdl/isa_pkg.sv
hdl/dispatch_if.sv
hdl/issue_if.sv
hdl/rename_table.sv
hdl/reservation_station.sv
hdl/exec_complete.sv
hdl/issue_core.sv
sim/issue_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module issue_core_tb -o issue_core_sim \
  && ./obj_dir/issue_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
